//--- synth_macros.svh
`ifndef SYNTH_MACROS_SVH
`define SYNTH_MACROS_SVH

// Voice engine timing
`define N_VOICES        4     // Time multiplexed voices
`define FRAME_CYCLES    384   // sys_clk cycles per audio sample
`define BIT_HALF_CYCLES 4     // Half period of DAC bit clock
`define SLOT_BITS       24    // Serial bits per channel

// Datapath widths
`define SAMPLE_W        16
`define PHASE_W         24
`define GAIN_W          8     // Velocity, volume, balance
`define MIX_SHIFT       10    // Scale back after master volume

// Register interface
`define REG_ADDR_W      5
`define REG_DATA_W      24
`define ADDR_MASTER_VOL 16
`define ADDR_BALANCE    17

`endif

//--- logic/audio_pkg.sv
`include "synth_macros.svh"

package audio_pkg;

    // Signed PCM sample as sent to the DAC
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // Sum of all voices, guard bits for the voice count
    typedef logic signed [`SAMPLE_W+$clog2(`N_VOICES)-1:0] mix_acc_t;

    typedef logic [`PHASE_W-1:0] phase_t;   // Phase and frequency increment

    // Unsigned gain, 255 is roughly unity
    typedef logic [`GAIN_W-1:0] gain_t;

endpackage

//--- logic/control_pkg.sv
`include "synth_macros.svh"

package control_pkg;

    // Waveform select, bits 2..1 of the voice control word
    typedef enum logic [1:0] {
        SHAPE_SAW      = 2'd0,
        SHAPE_SQUARE   = 2'd1,
        SHAPE_TRIANGLE = 2'd2,
        SHAPE_MUTE     = 2'd3
    } wave_shape_e;

    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;   // voice*4 + field, or global
    typedef logic [`REG_DATA_W-1:0] reg_data_t;

    // Voice number, also the slot index within a frame
    typedef logic [$clog2(`N_VOICES)-1:0] voice_idx_t;

endpackage

//--- logic/frame_timer.sv
`timescale 1ns/1ps
`include "synth_macros.svh"

module frame_timer import control_pkg::*; (
    input  logic       sys_clk,
    input  logic       i_reset,
    output logic       o_frame_start,   // Count 0
    output logic       o_slot_valid,    // Counts 0 to N_VOICES-1
    output voice_idx_t o_slot_idx,
    output logic       o_bit_tick       // Every BIT_HALF_CYCLES
);
    localparam int CNT_W  = $clog2(`FRAME_CYCLES);
    localparam int HALF_W = $clog2(`BIT_HALF_CYCLES);
    localparam int IDX_W  = $bits(voice_idx_t);

    logic [CNT_W-1:0] frame_cnt;   // Position within the audio frame

    // Held at 0 in reset so count 0 is the first cycle after release
    always_ff @(posedge sys_clk) begin
        if (i_reset) begin
            frame_cnt <= '0;
        end else if (frame_cnt == CNT_W'(`FRAME_CYCLES - 1)) begin
            frame_cnt <= '0;   // Wrap
        end else begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // Strobes decoded straight from the count
    assign o_frame_start = (frame_cnt == '0);
    assign o_slot_valid  = (frame_cnt < CNT_W'(`N_VOICES));
    assign o_slot_idx    = frame_cnt[IDX_W-1:0];   // Equals count inside the slots

    // Power of two half period, low bits zero
    assign o_bit_tick = (frame_cnt[HALF_W-1:0] == '0);

endmodule

//--- logic/voice_regs.sv
`timescale 1ns/1ps
`include "synth_macros.svh"

module voice_regs import audio_pkg::*; import control_pkg::*; (
    input  logic        sys_clk,
    input  logic        i_reset,
    input  logic        i_wr_en,
    input  reg_addr_t   i_wr_addr,
    input  reg_data_t   i_wr_data,
    input  voice_idx_t  i_slot_idx,     // Voice read out this cycle
    output phase_t      o_freq,
    output wave_shape_e o_shape,
    output logic        o_enable,
    output gain_t       o_velocity,
    output gain_t       o_master_vol,
    output gain_t       o_balance,
    output logic        o_restart,      // Control word written with enable set
    output voice_idx_t  o_restart_idx
);
    localparam int IDX_W = $bits(voice_idx_t);

    // Per voice records
    phase_t      freq_q     [`N_VOICES];
    wave_shape_e shape_q    [`N_VOICES];
    logic        enable_q   [`N_VOICES];
    gain_t       velocity_q [`N_VOICES];

    voice_idx_t wr_voice;      // Voice field of the address
    logic [1:0] wr_field;      // 0 freq, 1 control, 2 velocity
    logic       wr_is_voice;   // Address inside the voice block

    assign wr_field    = i_wr_addr[1:0];
    assign wr_voice    = i_wr_addr[2 +: IDX_W];
    assign wr_is_voice = (i_wr_addr < reg_addr_t'(4 * `N_VOICES));

    always_ff @(posedge sys_clk) begin
        if (i_reset) begin
            for (int v = 0; v < `N_VOICES; v++) begin
                freq_q[v]     <= '0;
                shape_q[v]    <= SHAPE_MUTE;
                enable_q[v]   <= 1'b0;
                velocity_q[v] <= '0;
            end
            o_master_vol  <= gain_t'(255);   // Full scale
            o_balance     <= gain_t'(128);   // Centre
            o_restart     <= 1'b0;
            o_restart_idx <= '0;
        end else begin
            o_restart <= 1'b0;   // Single cycle pulse
            if (i_wr_en && wr_is_voice) begin
                case (wr_field)
                    2'd0: freq_q[wr_voice] <= i_wr_data[`PHASE_W-1:0];
                    2'd1: begin
                        enable_q[wr_voice] <= i_wr_data[0];
                        shape_q[wr_voice]  <= wave_shape_e'(i_wr_data[2:1]);
                        o_restart          <= i_wr_data[0];   // Note on restarts phase
                        o_restart_idx      <= wr_voice;
                    end
                    2'd2: velocity_q[wr_voice] <= i_wr_data[`GAIN_W-1:0];
                    default: ;   // Field 3 unmapped
                endcase
            end
            if (i_wr_en && i_wr_addr == reg_addr_t'(`ADDR_MASTER_VOL)) begin
                o_master_vol <= i_wr_data[`GAIN_W-1:0];
            end
            if (i_wr_en && i_wr_addr == reg_addr_t'(`ADDR_BALANCE)) begin
                o_balance <= i_wr_data[`GAIN_W-1:0];
            end
        end
    end

    // Combinational read of the current slot
    assign o_freq     = freq_q[i_slot_idx];
    assign o_shape    = shape_q[i_slot_idx];
    assign o_enable   = enable_q[i_slot_idx];
    assign o_velocity = velocity_q[i_slot_idx];

endmodule

//--- logic/oscillator.sv
`timescale 1ns/1ps
`include "synth_macros.svh"

module oscillator import audio_pkg::*; import control_pkg::*; (
    input  logic        sys_clk,
    input  logic        i_reset,
    input  logic        i_slot_valid,
    input  voice_idx_t  i_slot_idx,
    input  phase_t      i_freq,
    input  wave_shape_e i_shape,
    input  logic        i_enable,
    input  gain_t       i_velocity,
    input  logic        i_restart,
    input  voice_idx_t  i_restart_idx,
    output sample_t     o_sample,         // One cycle after the slot
    output logic        o_sample_valid,
    output logic        o_sample_last     // Last voice of the frame
);
    localparam int MSB    = `SAMPLE_W - 1;
    localparam int PROD_W = `SAMPLE_W + `GAIN_W + 1;

    phase_t phase_q [`N_VOICES];   // One accumulator per voice
    phase_t cur_phase;             // Phase of the slot voice
    logic [`SAMPLE_W-1:0] u;       // Top bits of the phase
    logic [`SAMPLE_W-1:0] folded;  // Triangle fold, MSB always 0
    sample_t wave;
    logic signed [PROD_W-1:0] scaled;

    assign cur_phase = phase_q[i_slot_idx];
    assign u         = cur_phase[`PHASE_W-1 -: `SAMPLE_W];
    assign folded    = u[MSB] ? ~u : u;

    // Shared waveform stage
    always_comb begin
        wave = '0;
        if (i_enable) begin
            case (i_shape)
                SHAPE_SAW:      wave = {~u[MSB], u[MSB-1:0]};             // Offset binary to signed
                SHAPE_SQUARE:   wave = {u[MSB], {(`SAMPLE_W-1){~u[MSB]}}};   // +max or -max
                SHAPE_TRIANGLE: wave = {~folded[MSB-1], folded[MSB-2:0], 1'b0};
                default:        wave = '0;                                // Mute
            endcase
        end
    end

    // Velocity scaling, gain treated as unsigned
    assign scaled = wave * $signed({1'b0, i_velocity});

    always_ff @(posedge sys_clk) begin
        if (i_reset) begin
            for (int v = 0; v < `N_VOICES; v++) begin
                phase_q[v] <= '0;
            end
            o_sample_valid <= 1'b0;
            o_sample_last  <= 1'b0;
        end else begin
            o_sample_valid <= i_slot_valid;
            o_sample_last  <= i_slot_valid && (i_slot_idx == voice_idx_t'(`N_VOICES - 1));
            if (i_slot_valid && i_enable) begin
                phase_q[i_slot_idx] <= cur_phase + i_freq;   // Advance after use
            end
            // Restart wins over the advance
            if (i_restart) begin
                phase_q[i_restart_idx] <= '0;
            end
        end
    end

    // Sample register, qualified by o_sample_valid
    always_ff @(posedge sys_clk) begin
        if (i_slot_valid) begin
            o_sample <= scaled[`GAIN_W +: `SAMPLE_W];   // >>> GAIN_W
        end
    end

endmodule

//--- logic/mixer.sv
`timescale 1ns/1ps
`include "synth_macros.svh"

module mixer import audio_pkg::*; (
    input  logic    sys_clk,
    input  logic    i_reset,
    input  logic    i_frame_start,
    input  sample_t i_sample,
    input  logic    i_sample_valid,
    input  logic    i_sample_last,
    input  gain_t   i_master_vol,
    output sample_t o_mix,
    output logic    o_mix_valid     // One cycle after the last voice
);
    localparam int PROD_W = $bits(mix_acc_t) + `GAIN_W + 1;

    mix_acc_t acc_q;                   // Running sum of the frame
    mix_acc_t total;                   // Sum including this sample
    logic signed [PROD_W-1:0] scaled;  // After master volume

    assign total  = acc_q + mix_acc_t'(i_sample);   // Sign extended
    assign scaled = total * $signed({1'b0, i_master_vol});

    always_ff @(posedge sys_clk) begin
        if (i_reset) begin
            acc_q       <= '0;
            o_mix       <= '0;
            o_mix_valid <= 1'b0;
        end else begin
            o_mix_valid <= i_sample_valid && i_sample_last;
            if (i_frame_start) begin
                acc_q <= '0;   // New frame
            end else if (i_sample_valid) begin
                acc_q <= total;
            end
            // Full scale of four voices still fits after the shift
            if (i_sample_valid && i_sample_last) begin
                o_mix <= scaled[`MIX_SHIFT +: `SAMPLE_W];
            end
        end
    end

endmodule

//--- logic/pan.sv
`timescale 1ns/1ps
`include "synth_macros.svh"

module pan import audio_pkg::*; (
    input  logic    sys_clk,
    input  logic    i_reset,
    input  sample_t i_mix,
    input  logic    i_mix_valid,
    input  gain_t   i_balance,    // 0 full left, 255 full right
    output sample_t o_left,
    output sample_t o_right
);
    localparam int PROD_W = `SAMPLE_W + `GAIN_W + 1;

    gain_t left_gain;
    logic signed [PROD_W-1:0] left_prod;
    logic signed [PROD_W-1:0] right_prod;

    assign left_gain  = ~i_balance;   // 255 - balance
    assign left_prod  = i_mix * $signed({1'b0, left_gain});
    assign right_prod = i_mix * $signed({1'b0, i_balance});

    // Zero until the first mix so the opening frame is silent
    always_ff @(posedge sys_clk) begin
        if (i_reset) begin
            o_left  <= '0;
            o_right <= '0;
        end else if (i_mix_valid) begin
            o_left  <= left_prod[`GAIN_W +: `SAMPLE_W];    // >>> 8
            o_right <= right_prod[`GAIN_W +: `SAMPLE_W];
        end
    end

endmodule

//--- logic/dac_transmitter.sv
`timescale 1ns/1ps
`include "synth_macros.svh"

module dac_transmitter import audio_pkg::*; (
    input  logic    sys_clk,
    input  logic    i_reset,
    input  logic    i_frame_start,
    input  logic    i_bit_tick,
    input  sample_t i_left,
    input  sample_t i_right,
    output logic    o_bclk,
    output logic    o_lrclk,   // Low left, high right
    output logic    o_sd
);
    localparam int FRAME_BITS = 2 * `SLOT_BITS;
    localparam int PAD_W      = `SLOT_BITS - `SAMPLE_W;
    localparam int CNT_W      = $clog2(FRAME_BITS + 1);

    logic [FRAME_BITS-1:0] shift_q;   // Left slot then right slot
    logic [CNT_W-1:0]      bit_cnt;   // Index of next bit to present
    logic                  fall;      // Tick while bclk is high

    // Even tick count per frame, so count 0 is always a rising edge
    assign fall = i_bit_tick && o_bclk;

    always_ff @(posedge sys_clk) begin
        if (i_reset) begin
            o_bclk  <= 1'b0;
            o_lrclk <= 1'b0;
            o_sd    <= 1'b0;
            bit_cnt <= '0;
        end else begin
            if (i_bit_tick) begin
                o_bclk <= ~o_bclk;
            end
            if (i_frame_start) begin
                bit_cnt <= '0;
            end else if (fall) begin
                // Data and LR change together on the falling edge
                o_sd    <= shift_q[FRAME_BITS-1];
                o_lrclk <= (bit_cnt >= CNT_W'(`SLOT_BITS));
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // MSB first, sample padded with zeros to the slot width
    always_ff @(posedge sys_clk) begin
        if (i_frame_start) begin
            shift_q <= {i_left, {PAD_W{1'b0}}, i_right, {PAD_W{1'b0}}};
        end else if (fall) begin
            shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
        end
    end

endmodule

//--- logic/synth_top.sv
`timescale 1ns/1ps
`include "synth_macros.svh"

module synth_top import audio_pkg::*; import control_pkg::*; (
    input  logic      sys_clk,
    input  logic      i_reset,
    input  logic      i_wr_en,
    input  reg_addr_t i_wr_addr,
    input  reg_data_t i_wr_data,
    output logic      o_dac_bclk,
    output logic      o_dac_lrclk,
    output logic      o_dac_sd
);
    // Frame strobes
    logic        frame_start;
    logic        slot_valid;
    voice_idx_t  slot_idx;
    logic        bit_tick;

    // Settings of the slot voice
    phase_t      freq;
    wave_shape_e shape;
    logic        enable;
    gain_t       velocity;
    gain_t       master_vol;
    gain_t       balance;
    logic        restart;
    voice_idx_t  restart_idx;

    // Audio path
    sample_t     sample;
    logic        sample_valid;
    logic        sample_last;
    sample_t     mix;
    logic        mix_valid;
    sample_t     left;
    sample_t     right;

    frame_timer u_frame_timer (
        .sys_clk       (sys_clk),
        .i_reset       (i_reset),
        .o_frame_start (frame_start),
        .o_slot_valid  (slot_valid),
        .o_slot_idx    (slot_idx),
        .o_bit_tick    (bit_tick)
    );

    voice_regs u_voice_regs (
        .sys_clk       (sys_clk),
        .i_reset       (i_reset),
        .i_wr_en       (i_wr_en),
        .i_wr_addr     (i_wr_addr),
        .i_wr_data     (i_wr_data),
        .i_slot_idx    (slot_idx),
        .o_freq        (freq),
        .o_shape       (shape),
        .o_enable      (enable),
        .o_velocity    (velocity),
        .o_master_vol  (master_vol),
        .o_balance     (balance),
        .o_restart     (restart),
        .o_restart_idx (restart_idx)
    );

    oscillator u_oscillator (
        .sys_clk        (sys_clk),
        .i_reset        (i_reset),
        .i_slot_valid   (slot_valid),
        .i_slot_idx     (slot_idx),
        .i_freq         (freq),
        .i_shape        (shape),
        .i_enable       (enable),
        .i_velocity     (velocity),
        .i_restart      (restart),
        .i_restart_idx  (restart_idx),
        .o_sample       (sample),
        .o_sample_valid (sample_valid),
        .o_sample_last  (sample_last)
    );

    mixer u_mixer (
        .sys_clk        (sys_clk),
        .i_reset        (i_reset),
        .i_frame_start  (frame_start),
        .i_sample       (sample),
        .i_sample_valid (sample_valid),
        .i_sample_last  (sample_last),
        .i_master_vol   (master_vol),
        .o_mix          (mix),
        .o_mix_valid    (mix_valid)
    );

    pan u_pan (
        .sys_clk     (sys_clk),
        .i_reset     (i_reset),
        .i_mix       (mix),
        .i_mix_valid (mix_valid),
        .i_balance   (balance),
        .o_left      (left),
        .o_right     (right)
    );

    // Sends the previous frame's pair
    dac_transmitter u_dac_transmitter (
        .sys_clk       (sys_clk),
        .i_reset       (i_reset),
        .i_frame_start (frame_start),
        .i_bit_tick    (bit_tick),
        .i_left        (left),
        .i_right       (right),
        .o_bclk        (o_dac_bclk),
        .o_lrclk       (o_dac_lrclk),
        .o_sd          (o_dac_sd)
    );

endmodule

//--- tb/tb_synth_top.sv
`timescale 1ns/1ps
`include "synth_macros.svh"

module tb_synth_top import control_pkg::*; ();
    localparam int MAX_CYCLES = 40 * `FRAME_CYCLES + 2000;   // 34 frames of tests plus slack

    logic      sys_clk;
    logic      i_reset;
    logic      i_wr_en;
    reg_addr_t i_wr_addr;
    reg_data_t i_wr_data;
    logic      o_dac_bclk;
    logic      o_dac_lrclk;
    logic      o_dac_sd;

    // Reference model state, one entry per voice
    int          m_freq  [`N_VOICES];
    wave_shape_e m_shape [`N_VOICES];
    logic        m_en    [`N_VOICES];
    int          m_vel   [`N_VOICES];
    int          m_phase [`N_VOICES];
    int          m_master;
    int          m_balance;

    int exp_left[$];    // Pair sent in the current frame at the front
    int exp_right[$];
    wave_shape_e shape_sel [`N_VOICES];
    logic [23:0] rx_shift = '0;   // Last 24 serial bits
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    synth_top dut (
        .sys_clk     (sys_clk),
        .i_reset     (i_reset),
        .i_wr_en     (i_wr_en),
        .i_wr_addr   (i_wr_addr),
        .i_wr_data   (i_wr_data),
        .o_dac_bclk  (o_dac_bclk),
        .o_dac_lrclk (o_dac_lrclk),
        .o_dac_sd    (o_dac_sd)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;   // 20 ns period
    end

    // Run limit
    always @(posedge sys_clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the DAC stream stalled", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // Data and LR only move on a falling bit clock
    sd_on_fall: assert property (@(posedge sys_clk) disable iff (i_reset)
        !$stable(o_dac_sd) |-> $fell(o_dac_bclk)) else begin
        errors++;
        $display("Serial data changed away from a falling bit clock at %0t", $time);
    end
    lr_on_fall: assert property (@(posedge sys_clk) disable iff (i_reset)
        !$stable(o_dac_lrclk) |-> $fell(o_dac_bclk)) else begin
        errors++;
        $display("LR clock changed away from a falling bit clock at %0t", $time);
    end

    // Waveform value from the top 16 phase bits
    function automatic int wave_value(int v);
        int u;
        int folded;
        u = (m_phase[v] >> 8) & 32'hFFFF;
        if (!m_en[v]) return 0;
        case (m_shape[v])
            SHAPE_SAW:    return u - 32768;
            SHAPE_SQUARE: return (u < 32768) ? 32767 : -32768;
            SHAPE_TRIANGLE: begin
                folded = (u >= 32768) ? (65535 - u) : u;   // Fold the falling half
                return 2 * folded - 32768;
            end
            default:      return 0;
        endcase
    endfunction

    // Mirror of a register write in the model
    function automatic void track_write(int addr, int data);
        int v;
        v = addr / 4;
        if (addr < 4 * `N_VOICES) begin
            case (addr % 4)
                0: m_freq[v] = data & 32'hFF_FFFF;
                1: begin
                    m_en[v]    = (data & 1) != 0;
                    m_shape[v] = wave_shape_e'((data >> 1) & 3);
                    if (m_en[v]) m_phase[v] = 0;   // Note on restart
                end
                2: m_vel[v] = data & 255;
                default: ;
            endcase
        end else if (addr == `ADDR_MASTER_VOL) begin
            m_master = data & 255;
        end else if (addr == `ADDR_BALANCE) begin
            m_balance = data & 255;
        end
    endfunction

    // One frame of voices, mix and pan, then phase advance
    function automatic void predict_frame();
        int sum;
        int mix;
        sum = 0;
        for (int v = 0; v < `N_VOICES; v++) begin
            sum += (wave_value(v) * m_vel[v]) >>> 8;
            if (m_en[v]) m_phase[v] = (m_phase[v] + m_freq[v]) & 32'hFF_FFFF;
        end
        mix = (sum * m_master) >>> `MIX_SHIFT;
        exp_left.push_back((mix * (255 - m_balance)) >>> 8);
        exp_right.push_back((mix * m_balance) >>> 8);
    endfunction

    task automatic check_word(input string side, input logic [23:0] word, input int expected);
        int got;
        got = int'($signed(word[23:8]));
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("mismatch at %0t: %s sample expected %0d, got %0d",
                     $time, side, expected, got);
        end
        assert (word[7:0] == 8'h00) else begin
            errors++;
            $display("mismatch at %0t: %s padding expected 00, got %h", $time, side, word[7:0]);
        end
    endtask

    // Deserializer, MSB first on rising bit clock
    always @(posedge o_dac_bclk) begin
        if (!i_reset) rx_shift <= {rx_shift[22:0], o_dac_sd};
    end

    // Left slot complete when LR rises, model steps to this frame
    always @(posedge o_dac_lrclk) begin
        if (!i_reset) begin
            if (exp_left.size() > 0) check_word("left", rx_shift, exp_left.pop_front());
            predict_frame();
        end
    end

    // Right slot complete when LR falls in the next frame
    always @(negedge o_dac_lrclk) begin
        if (!i_reset && exp_right.size() > 0) begin
            check_word("right", rx_shift, exp_right.pop_front());
        end
    end

    task automatic write_reg(input int addr, input int data);
        @(posedge sys_clk);
        #1;
        i_wr_en   = 1'b1;
        i_wr_addr = reg_addr_t'(addr);
        i_wr_data = reg_data_t'(data);
        track_write(addr, data);
        @(posedge sys_clk);
        #1;
        i_wr_en = 1'b0;
    endtask

    task automatic write_control(input int v, input wave_shape_e shape, input logic en);
        write_reg(v * 4 + 1, (int'(shape) << 1) | int'(en));
    endtask

    // Control word last so the restart follows the settings
    task automatic set_voice(input int v, input int freq, input wave_shape_e shape, input int vel);
        write_reg(v * 4, freq);
        write_reg(v * 4 + 2, vel);
        write_control(v, shape, 1'b1);
    endtask

    // Returns just after LR rises, so writes apply from the next frame
    task automatic wait_frames(input int n);
        repeat (n) @(posedge o_dac_lrclk);
    endtask

    function automatic int wrap_freq();
        return 32'h34_0000 + ($urandom % 32'h0C_0000);   // Wraps within five steps
    endfunction

    initial begin
        void'($urandom(90));
        i_reset   = 1'b1;
        i_wr_en   = 1'b0;
        i_wr_addr = '0;
        i_wr_data = '0;
        for (int v = 0; v < `N_VOICES; v++) begin
            m_freq[v]  = 0;
            m_shape[v] = SHAPE_MUTE;
            m_en[v]    = 1'b0;
            m_vel[v]   = 0;
            m_phase[v] = 0;
        end
        m_master  = 255;
        m_balance = 128;
        exp_left.push_back(0);   // Frame 0 sends zeros
        exp_right.push_back(0);

        repeat (3) @(posedge sys_clk);
        #1 i_reset = 1'b0;
        assert (!o_dac_bclk && !o_dac_lrclk && !o_dac_sd) else begin
            errors++;
            $display("mismatch at %0t: DAC outputs expected low after reset, got %b%b%b",
                     $time, o_dac_bclk, o_dac_lrclk, o_dac_sd);
        end

        wait_frames(3);   // Idle, all silent
        set_voice(0, $urandom & 32'hFF_FFFF, SHAPE_SAW, 255);
        wait_frames(5);

        write_control(0, SHAPE_MUTE, 1'b0);
        set_voice(1, wrap_freq(), SHAPE_SQUARE, $urandom % 256);
        set_voice(2, wrap_freq(), SHAPE_TRIANGLE, $urandom % 256);
        wait_frames(6);

        for (int v = 0; v < `N_VOICES; v++) begin
            shape_sel[v] = wave_shape_e'($urandom % 3);
            set_voice(v, $urandom & 32'hFF_FFFF, shape_sel[v], $urandom % 256);
        end
        write_reg(`ADDR_MASTER_VOL, $urandom % 256);
        wait_frames(6);

        write_reg(`ADDR_BALANCE, 0);   // Right silent
        wait_frames(2);
        write_reg(`ADDR_BALANCE, 255); // Left silent
        wait_frames(2);
        write_reg(`ADDR_BALANCE, $urandom % 256);
        wait_frames(3);

        write_control(2, shape_sel[2], 1'b0);   // Voice drops out
        wait_frames(2);
        write_control(2, shape_sel[2], 1'b1);   // Back from phase zero
        wait_frames(5);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+.
logic/audio_pkg.sv
logic/control_pkg.sv
logic/frame_timer.sv
logic/voice_regs.sv
logic/oscillator.sv
logic/mixer.sv
logic/pan.sv
logic/dac_transmitter.sv
logic/synth_top.sv
tb/tb_synth_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_synth_top -f flist.f \
    && ./obj_dir/Vtb_synth_top > sim.log 2>&1 \
    || echo "Verilator build or simulation returned an error"

cat sim.log 2>/dev/null
grep -qx "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
